// File: all.f
logic/hins_pkg.sv
logic/axi_lite_slave_fsm.sv
logic/cfg_reg_bank.sv
logic/sync_pulse_gen.sv
logic/tick_timer.sv
logic/hins_ctrl_top.sv
+incdir+testbench
testbench/tb_hins_ctrl.sv

// File: testbench/tb_axi_tasks.svh
// ============================================================
// value compare, stops at first mismatch
// ============================================================
task automatic check_value(
    input string               name,
    input hins_pkg::reg_data_t expected,
    input hins_pkg::reg_data_t actual
);
    if (expected !== actual) begin
        $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
        $display("Testbench failed");
        $fatal(1, "stopping at first mismatch");
    end
endtask

// ============================================================
// AXI4-Lite master, one beat per call
// ============================================================
task automatic bus_write(
    input  hins_pkg::reg_addr_t addr,
    input  hins_pkg::reg_data_t data,
    input  hins_pkg::reg_strb_t strb,
    output hins_pkg::axi_resp_t resp
);
    int wait_cyc;
    @(posedge pll_clk_cpu_int);
    i_awvalid <= 1'b1;                          // AW and W together
    i_awaddr  <= addr;
    i_wvalid  <= 1'b1;
    i_wdata   <= data;
    i_wstrb   <= strb;
    @(negedge pll_clk_cpu_int);
    while (!(o_awready && o_wready)) begin
        @(negedge pll_clk_cpu_int);             // watchdog bounds this
    end
    @(posedge pll_clk_cpu_int);                 // AW/W transfer edge
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b0;
    i_bready  <= 1'b1;
    wait_cyc = 1;
    @(negedge pll_clk_cpu_int);
    while (!o_bvalid) begin
        @(negedge pll_clk_cpu_int);
        wait_cyc++;
    end
    check_value("write response latency", 1, wait_cyc);  // BVALID one cycle on
    resp = o_bresp;
    @(posedge pll_clk_cpu_int);                 // B transfer edge
    i_bready <= 1'b0;
endtask

task automatic bus_read(
    input  hins_pkg::reg_addr_t addr,
    output hins_pkg::reg_data_t data,
    output hins_pkg::axi_resp_t resp
);
    int wait_cyc;
    @(posedge pll_clk_cpu_int);
    i_arvalid <= 1'b1;
    i_araddr  <= addr;
    @(negedge pll_clk_cpu_int);
    while (!o_arready) begin
        @(negedge pll_clk_cpu_int);
    end
    @(posedge pll_clk_cpu_int);                 // AR transfer edge
    i_arvalid <= 1'b0;
    i_rready  <= 1'b1;
    wait_cyc = 1;
    @(negedge pll_clk_cpu_int);
    while (!o_rvalid) begin
        @(negedge pll_clk_cpu_int);
        wait_cyc++;
    end
    check_value("read data latency", 1, wait_cyc);
    data = o_rdata;                             // mid-cycle, stable
    resp = o_rresp;
    @(posedge pll_clk_cpu_int);                 // R transfer edge
    i_rready <= 1'b0;
endtask

// File: testbench/tb_hins_ctrl.sv
`timescale 1ns/1ps

module tb_hins_ctrl;

    localparam int TICK_DIV  = 8;               // fast timer for sim
    localparam int NUM_ROWS  = 16;
    localparam int SYNC_WAIT = 40;              // room for 3 rising edges at N = 5
    localparam int ZERO_WAIT = 50;
    localparam int WATCHDOG_CYCLES = 4 + NUM_ROWS * 200 + SYNC_WAIT + ZERO_WAIT
                                     + 20 * TICK_DIV;

    // short names for the register map
    localparam hins_pkg::reg_addr_t A_SYNC = hins_pkg::REG_SYNC_COUNT;
    localparam hins_pkg::reg_addr_t A_CTRL = hins_pkg::REG_TIMER_CTRL;
    localparam hins_pkg::reg_addr_t A_DAC  = hins_pkg::REG_DAC_RST;
    localparam hins_pkg::reg_addr_t A_TVAL = hins_pkg::REG_TIMER_VALUE;
    localparam hins_pkg::reg_addr_t A_BAD  = 8'h10;   // outside the map
    localparam hins_pkg::axi_resp_t OKAY   = hins_pkg::RESP_OKAY;
    localparam hins_pkg::axi_resp_t ERR    = hins_pkg::RESP_SLVERR;

    logic                pll_clk_cpu_int;
    logic                RST_EXT_N;
    logic                i_awvalid;
    hins_pkg::reg_addr_t i_awaddr;
    logic                o_awready;
    logic                i_wvalid;
    hins_pkg::reg_data_t i_wdata;
    hins_pkg::reg_strb_t i_wstrb;
    logic                o_wready;
    logic                o_bvalid;
    hins_pkg::axi_resp_t o_bresp;
    logic                i_bready;
    logic                i_arvalid;
    hins_pkg::reg_addr_t i_araddr;
    logic                o_arready;
    logic                o_rvalid;
    hins_pkg::reg_data_t o_rdata;
    hins_pkg::axi_resp_t o_rresp;
    logic                i_rready;
    logic                o_sync_out;
    logic                o_dac_rst;

    // stimulus table, one entry per column
    string               row_name  [NUM_ROWS];
    bit                  row_wr    [NUM_ROWS];  // 1 write, 0 read
    hins_pkg::reg_addr_t row_addr  [NUM_ROWS];
    hins_pkg::reg_data_t row_data  [NUM_ROWS];
    hins_pkg::reg_strb_t row_strb  [NUM_ROWS];
    hins_pkg::axi_resp_t row_resp  [NUM_ROWS];
    hins_pkg::reg_data_t row_rdata [NUM_ROWS];  // reads only
    int                  row_cnt;

    hins_pkg::reg_data_t rand_sync;             // from $urandom at start
    hins_pkg::reg_data_t rand_dac;
    hins_pkg::reg_data_t merged_sync;           // after lanes 0 and 2 rewritten

    `include "tb_axi_tasks.svh"

    hins_ctrl_top #(
        .TICK_DIV        (TICK_DIV)
    ) UUT (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .RST_EXT_N       (RST_EXT_N),
        .i_awvalid       (i_awvalid),
        .i_awaddr        (i_awaddr),
        .o_awready       (o_awready),
        .i_wvalid        (i_wvalid),
        .i_wdata         (i_wdata),
        .i_wstrb         (i_wstrb),
        .o_wready        (o_wready),
        .o_bvalid        (o_bvalid),
        .o_bresp         (o_bresp),
        .i_bready        (i_bready),
        .i_arvalid       (i_arvalid),
        .i_araddr        (i_araddr),
        .o_arready       (o_arready),
        .o_rvalid        (o_rvalid),
        .o_rdata         (o_rdata),
        .o_rresp         (o_rresp),
        .i_rready        (i_rready),
        .o_sync_out      (o_sync_out),
        .o_dac_rst       (o_dac_rst)
    );

    // ============================================================
    // clock and watchdog
    // ============================================================
    always begin
        #50;
        pll_clk_cpu_int = ~pll_clk_cpu_int;     // 100 ns period
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge pll_clk_cpu_int);
        $display("watchdog expired after %0d cycles, DUT stopped responding", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1, "run aborted by watchdog");
    end

    task automatic set_row(
        input string               name,
        input bit                  wr,
        input hins_pkg::reg_addr_t addr,
        input hins_pkg::reg_data_t data,
        input hins_pkg::reg_strb_t strb,
        input hins_pkg::axi_resp_t resp,
        input hins_pkg::reg_data_t rdata
    );
        row_name[row_cnt]  = name;
        row_wr[row_cnt]    = wr;
        row_addr[row_cnt]  = addr;
        row_data[row_cnt]  = data;
        row_strb[row_cnt]  = strb;
        row_resp[row_cnt]  = resp;
        row_rdata[row_cnt] = rdata;
        row_cnt++;
    endtask

    task automatic build_table();
        row_cnt = 0;
        // timer value first, before its first tick
        set_row("reset timer value", 1'b0, A_TVAL, '0, '0, OKAY, '0);
        set_row("reset sync count", 1'b0, A_SYNC, '0, '0, OKAY, '0);
        set_row("reset timer ctrl", 1'b0, A_CTRL, '0, '0, OKAY, '0);
        set_row("reset dac rst", 1'b0, A_DAC, '0, '0, OKAY, '0);
        set_row("write sync random", 1'b1, A_SYNC, rand_sync, 4'hF, OKAY, '0);
        set_row("read sync random", 1'b0, A_SYNC, '0, '0, OKAY, rand_sync);
        set_row("write dac random", 1'b1, A_DAC, rand_dac, 4'hF, OKAY, '0);
        set_row("read dac random", 1'b0, A_DAC, '0, '0, OKAY, rand_dac);
        set_row("write sync lanes 0 2", 1'b1, A_SYNC, 32'hA5A5_A5A5, 4'b0101, OKAY, '0);
        set_row("read sync lanes 0 2", 1'b0, A_SYNC, '0, '0, OKAY, merged_sync);
        set_row("write timer value", 1'b1, A_TVAL, 32'hFFFF_FFFF, 4'hF, ERR, '0);
        set_row("write unmapped", 1'b1, A_BAD, 32'hFFFF_FFFF, 4'hF, ERR, '0);
        set_row("read unmapped", 1'b0, A_BAD, '0, '0, ERR, '0);
        set_row("sync after bad writes", 1'b0, A_SYNC, '0, '0, OKAY, merged_sync);
        set_row("ctrl after bad writes", 1'b0, A_CTRL, '0, '0, OKAY, '0);
        set_row("dac after bad writes", 1'b0, A_DAC, '0, '0, OKAY, rand_dac);
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        hins_pkg::reg_data_t rd_val;
        hins_pkg::axi_resp_t resp;
        int                  rises;
        int                  last_rise;
        int                  high_cnt;
        logic                prev;

        pll_clk_cpu_int = 1'b0;
        RST_EXT_N <= 1'b0;
        i_awvalid <= 1'b0;
        i_awaddr  <= '0;
        i_wvalid  <= 1'b0;
        i_wdata   <= '0;
        i_wstrb   <= '0;
        i_bready  <= 1'b0;
        i_arvalid <= 1'b0;
        i_araddr  <= '0;
        i_rready  <= 1'b0;

        void'($urandom(58));                    // one seed for the run
        rand_sync   = $urandom;
        rand_dac    = $urandom;
        merged_sync = {rand_sync[31:24], 8'hA5, rand_sync[15:8], 8'hA5};
        build_table();

        repeat (4) @(posedge pll_clk_cpu_int);
        RST_EXT_N <= 1'b1;

        // table rows, access path and error responses
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (row_wr[i]) begin
                bus_write(row_addr[i], row_data[i], row_strb[i], resp);
                check_value({row_name[i], " bresp"}, row_resp[i], resp);
            end else begin
                bus_read(row_addr[i], rd_val, resp);
                check_value({row_name[i], " rresp"}, row_resp[i], resp);
                check_value({row_name[i], " rdata"}, row_rdata[i], rd_val);
            end
        end

        // ============================================================
        // sync generator, N = 5 then 0
        // ============================================================
        bus_write(A_SYNC, 32'd5, 4'hF, resp);
        check_value("sync count 5 bresp", OKAY, resp);
        @(negedge pll_clk_cpu_int);
        prev      = o_sync_out;
        rises     = 0;
        last_rise = 0;
        for (int cyc = 1; cyc <= SYNC_WAIT && rises < 3; cyc++) begin
            @(negedge pll_clk_cpu_int);
            if (o_sync_out && !prev) begin
                if (rises > 0) begin
                    check_value("sync rise spacing", 10, cyc - last_rise);  // 2N
                end
                last_rise = cyc;
                rises++;
            end
            prev = o_sync_out;
        end
        check_value("sync rising edges seen", 3, rises);

        bus_write(A_SYNC, 32'd0, 4'hF, resp);
        check_value("sync count 0 bresp", OKAY, resp);
        repeat (2) @(negedge pll_clk_cpu_int); // load reaches the generator
        high_cnt = 0;
        repeat (ZERO_WAIT) begin
            @(negedge pll_clk_cpu_int);
            if (o_sync_out) begin
                high_cnt++;
            end
        end
        check_value("sync high cycles at N = 0", 0, high_cnt);

        // ============================================================
        // timer hold and release
        // ============================================================
        bus_write(A_CTRL, 32'd1, 4'hF, resp);
        check_value("timer hold bresp", OKAY, resp);
        bus_read(A_TVAL, rd_val, resp);
        check_value("held timer rresp", OKAY, resp);
        check_value("held timer value", 0, rd_val);
        bus_write(A_CTRL, 32'd0, 4'hF, resp);
        check_value("timer release bresp", OKAY, resp);
        repeat (20 * TICK_DIV) @(posedge pll_clk_cpu_int);
        bus_read(A_TVAL, rd_val, resp);
        check_value("running timer rresp", OKAY, resp);
        check_value($sformatf("timer value %0d within 19..22", rd_val), 1,
                    (rd_val >= 19 && rd_val <= 22));

        // ============================================================
        // DAC reset line
        // ============================================================
        bus_write(A_DAC, 32'd1, 4'hF, resp);
        check_value("dac set bresp", OKAY, resp);
        @(negedge pll_clk_cpu_int);
        check_value("dac reset line high", 1, o_dac_rst);
        bus_write(A_DAC, 32'd0, 4'hF, resp);
        check_value("dac clear bresp", OKAY, resp);
        @(negedge pll_clk_cpu_int);
        check_value("dac reset line low", 0, o_dac_rst);

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: logic/hins_ctrl_top.sv
`timescale 1ns/1ps

module hins_ctrl_top #(
    parameter int TICK_DIV = 10000              // cpu cycles per timer tick
) (
    input  logic                pll_clk_cpu_int,
    input  logic                RST_EXT_N,

    // AXI4-Lite write address / data / response
    input  logic                i_awvalid,
    input  hins_pkg::reg_addr_t i_awaddr,
    output logic                o_awready,
    input  logic                i_wvalid,
    input  hins_pkg::reg_data_t i_wdata,
    input  hins_pkg::reg_strb_t i_wstrb,
    output logic                o_wready,
    output logic                o_bvalid,
    output hins_pkg::axi_resp_t o_bresp,
    input  logic                i_bready,

    // AXI4-Lite read address / data
    input  logic                i_arvalid,
    input  hins_pkg::reg_addr_t i_araddr,
    output logic                o_arready,
    output logic                o_rvalid,
    output hins_pkg::reg_data_t o_rdata,
    output hins_pkg::axi_resp_t o_rresp,
    input  logic                i_rready,

    // board side
    output logic                o_sync_out,     // sync probe
    output logic                o_dac_rst       // DAC reset line
);

    // register access strobes, fsm -> bank
    logic                wr_en;
    logic                rd_en;
    hins_pkg::reg_addr_t reg_addr;
    hins_pkg::reg_data_t wr_data;
    hins_pkg::reg_strb_t wr_strb;
    hins_pkg::reg_data_t rd_data;               // bank -> fsm, comb
    logic                rd_err;

    // bank outputs to the datapath
    hins_pkg::reg_data_t sync_count;
    logic                sync_load;
    logic                timer_hold;
    hins_pkg::reg_data_t timer_value;

    // ============================================================
    // bus slave
    // ============================================================
    axi_lite_slave_fsm u_axi_slave (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .RST_EXT_N       (RST_EXT_N),
        .i_awvalid       (i_awvalid),
        .i_awaddr        (i_awaddr),
        .i_wvalid        (i_wvalid),
        .i_wdata         (i_wdata),
        .i_wstrb         (i_wstrb),
        .i_bready        (i_bready),
        .i_arvalid       (i_arvalid),
        .i_araddr        (i_araddr),
        .i_rready        (i_rready),
        .i_rd_data       (rd_data),
        .i_rd_err        (rd_err),
        .o_awready       (o_awready),
        .o_wready        (o_wready),
        .o_bvalid        (o_bvalid),
        .o_bresp         (o_bresp),
        .o_arready       (o_arready),
        .o_rvalid        (o_rvalid),
        .o_rdata         (o_rdata),
        .o_rresp         (o_rresp),
        .o_wr_en         (wr_en),
        .o_rd_en         (rd_en),
        .o_addr          (reg_addr),
        .o_wr_data       (wr_data),
        .o_wr_strb       (wr_strb)
    );

    // ============================================================
    // software registers
    // ============================================================
    cfg_reg_bank u_reg_bank (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .RST_EXT_N       (RST_EXT_N),
        .i_wr_en         (wr_en),
        .i_rd_en         (rd_en),
        .i_addr          (reg_addr),
        .i_wr_data       (wr_data),
        .i_wr_strb       (wr_strb),
        .i_timer_value   (timer_value),
        .o_rd_data       (rd_data),
        .o_rd_err        (rd_err),
        .o_sync_count    (sync_count),
        .o_sync_load     (sync_load),
        .o_timer_hold    (timer_hold),
        .o_dac_rst       (o_dac_rst)
    );

    // ============================================================
    // sync and timer
    // ============================================================
    sync_pulse_gen u_sync_gen (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .RST_EXT_N       (RST_EXT_N),
        .i_sync_count    (sync_count),
        .i_sync_load     (sync_load),
        .o_sync_out      (o_sync_out)
    );

    tick_timer #(
        .TICK_DIV        (TICK_DIV)
    ) u_timer (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .RST_EXT_N       (RST_EXT_N),
        .i_hold          (timer_hold),
        .o_timer         (timer_value)
    );

endmodule

// File: logic/tick_timer.sv
`timescale 1ns/1ps

module tick_timer #(
    parameter int TICK_DIV = 10000              // cpu cycles per tick
) (
    input  logic                pll_clk_cpu_int,
    input  logic                RST_EXT_N,
    input  logic                i_hold,         // software hold, clears all
    output hins_pkg::reg_data_t o_timer
);

    // prescaler width, at least one bit
    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICK_DIV - 1);

    logic [PRE_W-1:0]    pre_q;                 // 0 .. TICK_DIV-1
    hins_pkg::reg_data_t tick_q;                // free-running tick count
    logic                tick_en;

    assign tick_en = (pre_q == PRE_LAST);       // one pulse per TICK_DIV

    // ============================================================
    // prescaler
    // ============================================================
    always_ff @(posedge pll_clk_cpu_int or negedge RST_EXT_N) begin
        if (!RST_EXT_N) begin
            pre_q <= '0;
        end else if (i_hold || tick_en) begin
            pre_q <= '0;                        // wrap or held
        end else begin
            pre_q <= pre_q + 1'b1;
        end
    end

    // ============================================================
    // tick counter
    // ============================================================
    always_ff @(posedge pll_clk_cpu_int or negedge RST_EXT_N) begin
        if (!RST_EXT_N) begin
            tick_q <= '0;
        end else if (i_hold) begin
            tick_q <= '0;                       // held at 0
        end else if (tick_en) begin
            tick_q <= tick_q + 1'b1;            // wraps at 2^32
        end
    end

    assign o_timer = tick_q;

endmodule

// File: logic/sync_pulse_gen.sv
`timescale 1ns/1ps

module sync_pulse_gen (
    input  logic                pll_clk_cpu_int,
    input  logic                RST_EXT_N,
    input  hins_pkg::reg_data_t i_sync_count,   // half-period N in cycles
    input  logic                i_sync_load,    // count just rewritten
    output logic                o_sync_out
);

    hins_pkg::reg_data_t cnt_q;                 // cycles into current half
    logic                sync_q;
    logic                half_done;

    // last cycle of the half-period, N > 0 only
    assign half_done = (cnt_q >= i_sync_count - 1'b1);

    // ============================================================
    // half-period counter and toggle
    // ============================================================
    always_ff @(posedge pll_clk_cpu_int or negedge RST_EXT_N) begin
        if (!RST_EXT_N) begin
            cnt_q  <= '0;
            sync_q <= 1'b0;
        end else if (i_sync_load || (i_sync_count == '0)) begin
            cnt_q  <= '0;                       // restart, output low
            sync_q <= 1'b0;                     // N = 0 parks here
        end else if (half_done) begin
            cnt_q  <= '0;
            sync_q <= ~sync_q;                  // toggle every N cycles
        end else begin
            cnt_q  <= cnt_q + 1'b1;
        end
    end

    assign o_sync_out = sync_q;

endmodule

// File: logic/cfg_reg_bank.sv
`timescale 1ns/1ps

module cfg_reg_bank (
    input  logic                pll_clk_cpu_int,
    input  logic                RST_EXT_N,
    input  logic                i_wr_en,        // write strobe from slave
    input  logic                i_rd_en,        // read strobe from slave
    input  hins_pkg::reg_addr_t i_addr,
    input  hins_pkg::reg_data_t i_wr_data,
    input  hins_pkg::reg_strb_t i_wr_strb,
    input  hins_pkg::reg_data_t i_timer_value,  // live timer count
    output hins_pkg::reg_data_t o_rd_data,
    output logic                o_rd_err,
    output hins_pkg::reg_data_t o_sync_count,
    output logic                o_sync_load,    // restart pulse to sync gen
    output logic                o_timer_hold,
    output logic                o_dac_rst
);

    hins_pkg::reg_data_t sync_count_q;          // 0x00
    hins_pkg::reg_data_t timer_ctrl_q;          // 0x04
    hins_pkg::reg_data_t dac_rst_q;             // 0x08
    logic                sync_load_q;

    logic hit_sync;
    logic hit_ctrl;
    logic hit_dac;
    logic hit_timer;
    logic hit_rw;                               // writable offset
    logic wr_bad;
    logic rd_bad;

    // merge enabled byte lanes of a write into the old word
    function automatic hins_pkg::reg_data_t merge_bytes(
        input hins_pkg::reg_data_t old_val,
        input hins_pkg::reg_data_t new_val,
        input hins_pkg::reg_strb_t strb
    );
        hins_pkg::reg_data_t res;
        res = old_val;
        for (int b = 0; b < $bits(strb); b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    // ============================================================
    // address decode
    // ============================================================
    assign hit_sync  = (i_addr == hins_pkg::REG_SYNC_COUNT);
    assign hit_ctrl  = (i_addr == hins_pkg::REG_TIMER_CTRL);
    assign hit_dac   = (i_addr == hins_pkg::REG_DAC_RST);
    assign hit_timer = (i_addr == hins_pkg::REG_TIMER_VALUE);
    assign hit_rw    = hit_sync | hit_ctrl | hit_dac;

    assign wr_bad   = !hit_rw;                  // unmapped or read-only
    assign rd_bad   = !(hit_rw | hit_timer);    // unmapped only
    assign o_rd_err = (i_wr_en & wr_bad) | (i_rd_en & rd_bad);

    // ============================================================
    // writable registers
    // ============================================================
    always_ff @(posedge pll_clk_cpu_int or negedge RST_EXT_N) begin
        if (!RST_EXT_N) begin
            sync_count_q <= '0;
            timer_ctrl_q <= '0;                 // timer runs after reset
            dac_rst_q    <= '0;
            sync_load_q  <= 1'b0;
        end else begin
            sync_load_q <= i_wr_en && hit_sync;  // lines up with new count
            if (i_wr_en && hit_sync) begin
                sync_count_q <= merge_bytes(sync_count_q, i_wr_data, i_wr_strb);
            end
            if (i_wr_en && hit_ctrl) begin
                timer_ctrl_q <= merge_bytes(timer_ctrl_q, i_wr_data, i_wr_strb);
            end
            if (i_wr_en && hit_dac) begin
                dac_rst_q <= merge_bytes(dac_rst_q, i_wr_data, i_wr_strb);
            end
        end
    end

    // ============================================================
    // read mux
    // ============================================================
    always_comb begin
        case (i_addr)
            hins_pkg::REG_SYNC_COUNT:  o_rd_data = sync_count_q;
            hins_pkg::REG_TIMER_CTRL:  o_rd_data = timer_ctrl_q;
            hins_pkg::REG_DAC_RST:     o_rd_data = dac_rst_q;
            hins_pkg::REG_TIMER_VALUE: o_rd_data = i_timer_value;
            default:                   o_rd_data = '0;   // bad offset reads 0
        endcase
    end

    assign o_sync_count = sync_count_q;
    assign o_sync_load  = sync_load_q;
    assign o_timer_hold = timer_ctrl_q[0];      // only bit 0 has meaning
    assign o_dac_rst    = dac_rst_q[0];

endmodule

// File: logic/axi_lite_slave_fsm.sv
`timescale 1ns/1ps

module axi_lite_slave_fsm (
    input  logic                pll_clk_cpu_int,
    input  logic                RST_EXT_N,

    // from bus master
    input  logic                i_awvalid,
    input  hins_pkg::reg_addr_t i_awaddr,
    input  logic                i_wvalid,
    input  hins_pkg::reg_data_t i_wdata,
    input  hins_pkg::reg_strb_t i_wstrb,
    input  logic                i_bready,
    input  logic                i_arvalid,
    input  hins_pkg::reg_addr_t i_araddr,
    input  logic                i_rready,

    // from register bank, comb for presented address
    input  hins_pkg::reg_data_t i_rd_data,
    input  logic                i_rd_err,

    // to bus master
    output logic                o_awready,
    output logic                o_wready,
    output logic                o_bvalid,
    output hins_pkg::axi_resp_t o_bresp,
    output logic                o_arready,
    output logic                o_rvalid,
    output hins_pkg::reg_data_t o_rdata,
    output hins_pkg::axi_resp_t o_rresp,

    // to register bank
    output logic                o_wr_en,        // one-cycle write strobe
    output logic                o_rd_en,        // one-cycle read strobe
    output hins_pkg::reg_addr_t o_addr,
    output hins_pkg::reg_data_t o_wr_data,
    output hins_pkg::reg_strb_t o_wr_strb
);

    hins_pkg::axi_state_t state_q;
    hins_pkg::axi_state_t state_d;

    logic                wr_go;                 // AW+W accepted this cycle
    logic                rd_go;                 // AR accepted this cycle
    hins_pkg::axi_resp_t bresp_q;
    hins_pkg::axi_resp_t rresp_q;
    hins_pkg::reg_data_t rdata_q;

    // ============================================================
    // arbitration, write beats read
    // ============================================================
    assign wr_go = (state_q == hins_pkg::ST_IDLE) && i_awvalid && i_wvalid;
    assign rd_go = (state_q == hins_pkg::ST_IDLE) && i_arvalid && !wr_go;

    assign o_awready = wr_go;                   // AW and W taken together
    assign o_wready  = wr_go;
    assign o_arready = rd_go;

    // register side strobes, same cycle as the handshake
    assign o_wr_en   = wr_go;
    assign o_rd_en   = rd_go;
    assign o_addr    = wr_go ? i_awaddr : i_araddr;
    assign o_wr_data = i_wdata;
    assign o_wr_strb = i_wstrb;

    // ============================================================
    // state machine
    // ============================================================
    always_comb begin
        state_d = state_q;                      // hold by default
        case (state_q)
            hins_pkg::ST_IDLE: begin
                if (wr_go) begin
                    state_d = hins_pkg::ST_WRESP;
                end else if (rd_go) begin
                    state_d = hins_pkg::ST_RDATA;
                end
            end
            hins_pkg::ST_WRESP: begin
                if (i_bready) begin
                    state_d = hins_pkg::ST_IDLE;    // response taken
                end
            end
            hins_pkg::ST_RDATA: begin
                if (i_rready) begin
                    state_d = hins_pkg::ST_IDLE;
                end
            end
            default: state_d = hins_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge pll_clk_cpu_int or negedge RST_EXT_N) begin
        if (!RST_EXT_N) begin
            state_q <= hins_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ============================================================
    // response capture, held while master stalls
    // ============================================================
    always_ff @(posedge pll_clk_cpu_int) begin
        if (wr_go) begin
            bresp_q <= i_rd_err ? hins_pkg::RESP_SLVERR : hins_pkg::RESP_OKAY;
        end
        if (rd_go) begin
            rdata_q <= i_rd_data;               // 0 from bank on bad address
            rresp_q <= i_rd_err ? hins_pkg::RESP_SLVERR : hins_pkg::RESP_OKAY;
        end
    end

    assign o_bvalid = (state_q == hins_pkg::ST_WRESP);  // one cycle after AW/W
    assign o_bresp  = bresp_q;
    assign o_rvalid = (state_q == hins_pkg::ST_RDATA);  // one cycle after AR
    assign o_rdata  = rdata_q;
    assign o_rresp  = rresp_q;

endmodule

// File: logic/hins_pkg.sv
package hins_pkg;

    // ============================================================
    // bus widths
    // ============================================================
    localparam int DATA_W = 32;                 // register / bus word
    localparam int ADDR_W = 8;                  // register window, byte address
    localparam int STRB_W = DATA_W / 8;         // one strobe per byte lane

    typedef logic [DATA_W-1:0] reg_data_t;      // data word
    typedef logic [ADDR_W-1:0] reg_addr_t;      // byte address
    typedef logic [STRB_W-1:0] reg_strb_t;      // byte-lane write strobe
    typedef logic [1:0]        axi_resp_t;      // xRESP encoding

    // ============================================================
    // response codes
    // ============================================================
    localparam axi_resp_t RESP_OKAY   = 2'b00;  // normal access
    localparam axi_resp_t RESP_SLVERR = 2'b10;  // unmapped or read-only

    // ============================================================
    // register map
    // ============================================================
    localparam reg_addr_t REG_SYNC_COUNT  = 8'h00; // rw, sync half-period in cycles
    localparam reg_addr_t REG_TIMER_CTRL  = 8'h04; // rw, bit0 holds timer in reset
    localparam reg_addr_t REG_DAC_RST     = 8'h08; // rw, bit0 drives DAC reset
    localparam reg_addr_t REG_TIMER_VALUE = 8'h0C; // ro, current tick count

    // ============================================================
    // AXI4-Lite slave FSM states
    // ============================================================
    typedef enum logic [1:0] {
        ST_IDLE,                                // waiting for AW+W or AR
        ST_WRESP,                               // BVALID up, waiting BREADY
        ST_RDATA                                // RVALID up, waiting RREADY
    } axi_state_t;

endpackage
